/* glb_cfg_pkg.sv */
package glb_cfg_pkg;

    // ******************************************************************
    // sizing defaults
    // ******************************************************************

    localparam int DEFAULT_DATA_WIDTH = 32;  // bits per word.
    localparam int DEFAULT_BANK_WORDS = 64;  // words per bank, a power of two.
    localparam int DEFAULT_NUM_BANKS  = 3;   // any count of one or more.

    // ******************************************************************
    // address widths
    // ******************************************************************

    function automatic int local_addr_bits(input int bank_words);
        return (bank_words > 1) ? $clog2(bank_words) : 1;
    endfunction

    // a single bank still keeps a one bit index field.
    function automatic int bank_idx_bits(input int num_banks);
        return (num_banks > 1) ? $clog2(num_banks) : 1;
    endfunction

    function automatic int global_addr_bits(input int bank_words, input int num_banks);
        return local_addr_bits(bank_words) + bank_idx_bits(num_banks);
    endfunction

endpackage

/* glb_cmd_pkg.sv */
package glb_cmd_pkg;

    localparam int OP_WIDTH = 2;

    // command opcodes on the single command port.
    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP   = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2,
        OP_BCAST = 2'd3   // same word to one local address in every bank.
    } glb_op_e;

    // true for the opcodes that address a single bank through the bank field.
    function automatic logic op_targets_bank(input glb_op_e op);
        return (op == OP_READ) || (op == OP_WRITE);
    endfunction

endpackage

/* sram_sp_model.sv */
module sram_sp_model #(
    parameter int DATA_WIDTH = glb_cfg_pkg::DEFAULT_DATA_WIDTH,
    parameter int BANK_WORDS = glb_cfg_pkg::DEFAULT_BANK_WORDS,
    localparam int ADDR_WIDTH = glb_cfg_pkg::local_addr_bits(BANK_WORDS)
) (
    input  logic                  clk,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out
);

    logic [DATA_WIDTH-1:0] mem [BANK_WORDS];

    // ******************************************************************
    // array access
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= data_in;
        end
    end

    // q keeps its value between reads, as the macro output does.
    always_ff @(posedge clk) begin
        if (read_en) begin
            data_out <= mem[addr];
        end
    end

endmodule

/* glb_bank.sv */
module glb_bank #(
    parameter int DATA_WIDTH = glb_cfg_pkg::DEFAULT_DATA_WIDTH,
    parameter int BANK_WORDS = glb_cfg_pkg::DEFAULT_BANK_WORDS,
    localparam int ADDR_WIDTH = glb_cfg_pkg::local_addr_bits(BANK_WORDS)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out
);

    logic                  sram_read_en;
    logic                  read_en_d;
    logic [DATA_WIDTH-1:0] sram_q;
    logic [DATA_WIDTH-1:0] hold_q;

    assign sram_read_en = read_en & ~write_en;  // a write wins over a read.

    sram_sp_model #(
        .DATA_WIDTH (DATA_WIDTH),
        .BANK_WORDS (BANK_WORDS)
    ) u_sram (
        .clk      (clk),
        .read_en  (sram_read_en),
        .write_en (write_en),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (sram_q)
    );

    // ******************************************************************
    // read return and hold
    // ******************************************************************

    // marks the cycle in which sram_q carries a fresh word.
    always_ff @(posedge clk) begin
        if (reset) begin
            read_en_d <= 1'b0;
        end else begin
            read_en_d <= sram_read_en;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_q <= '0;
        end else if (read_en_d) begin
            hold_q <= sram_q;  // capture the fresh word before the bus moves on.
        end
    end

    assign data_out = read_en_d ? sram_q : hold_q;

    // ******************************************************************
    // assertions
    // ******************************************************************

    // the router never asks one bank for a read and a write together.
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (reset) !(read_en && write_en)
    ) else $error("bank got read_en and write_en in the same cycle.");

endmodule

/* glb_router.sv */
module glb_router #(
    parameter int DATA_WIDTH = glb_cfg_pkg::DEFAULT_DATA_WIDTH,
    parameter int BANK_WORDS = glb_cfg_pkg::DEFAULT_BANK_WORDS,
    parameter int NUM_BANKS  = glb_cfg_pkg::DEFAULT_NUM_BANKS,
    localparam int LOCAL_AW  = glb_cfg_pkg::local_addr_bits(BANK_WORDS),
    localparam int BANK_IW   = glb_cfg_pkg::bank_idx_bits(NUM_BANKS),
    localparam int GLOBAL_AW = glb_cfg_pkg::global_addr_bits(BANK_WORDS, NUM_BANKS)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  glb_cmd_pkg::glb_op_e   cmd_op,
    input  logic [GLOBAL_AW-1:0]   cmd_addr,
    input  logic [DATA_WIDTH-1:0]  cmd_wdata,
    output logic [NUM_BANKS-1:0]   bank_read_en,
    output logic [NUM_BANKS-1:0]   bank_write_en,
    output logic [LOCAL_AW-1:0]    bank_addr,
    output logic [DATA_WIDTH-1:0]  bank_wdata,
    output logic                   rd_issue,
    output logic [BANK_IW-1:0]     rd_bank,
    output logic                   cmd_err
);

    import glb_cmd_pkg::*;

    logic [BANK_IW-1:0] bank_idx;
    logic               bank_legal;
    logic               is_read;
    logic               is_write;
    logic               is_bcast;

    // ******************************************************************
    // address split and decode
    // ******************************************************************

    assign bank_idx   = cmd_addr[GLOBAL_AW-1:LOCAL_AW];
    assign bank_addr  = cmd_addr[LOCAL_AW-1:0];
    assign bank_wdata = cmd_wdata;

    // the bank count need not fill the index field.
    assign bank_legal = (int'(bank_idx) < NUM_BANKS);

    assign is_read  = cmd_valid && (cmd_op == OP_READ);
    assign is_write = cmd_valid && (cmd_op == OP_WRITE);
    assign is_bcast = cmd_valid && (cmd_op == OP_BCAST);

    // an index past the last bank never matches a loop entry, so it gets no enable.
    always_comb begin
        bank_read_en  = '0;
        bank_write_en = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_idx == BANK_IW'(i)) begin
                bank_read_en[i]  = is_read;
                bank_write_en[i] = is_write;
            end
            if (is_bcast) begin
                bank_write_en[i] = 1'b1;  // broadcast ignores the bank field.
            end
        end
    end

    assign rd_issue = is_read && bank_legal;
    assign rd_bank  = bank_idx;

    // one cycle error pulse for a dropped read or write.
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_err <= 1'b0;
        end else begin
            cmd_err <= cmd_valid && op_targets_bank(cmd_op) && !bank_legal;
        end
    end

    // ******************************************************************
    // assertions
    // ******************************************************************

    // the collector tracks a single bank per read, so at most one bank is read.
    a_read_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bank_read_en) && (rd_issue == (|bank_read_en))
    ) else $error("read enables are not one-hot or disagree with rd_issue.");

endmodule

/* glb_collector.sv */
module glb_collector #(
    parameter int DATA_WIDTH = glb_cfg_pkg::DEFAULT_DATA_WIDTH,
    parameter int NUM_BANKS  = glb_cfg_pkg::DEFAULT_NUM_BANKS,
    localparam int BANK_IW   = glb_cfg_pkg::bank_idx_bits(NUM_BANKS)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_issue,
    input  logic [BANK_IW-1:0]    rd_bank,
    input  logic [DATA_WIDTH-1:0] bank_rdata [NUM_BANKS],
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rdata_valid
);

    logic [BANK_IW-1:0] last_bank;

    // ******************************************************************
    // read tracking
    // ******************************************************************

    // the banks answer one cycle after the read, which matches this register.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_bank <= '0;
        end else if (rd_issue) begin
            last_bank <= rd_bank;
        end
    end

    // each bank holds its last read word, so this mux alone keeps rdata
    // stable between reads.
    assign rdata = bank_rdata[last_bank];

    // ******************************************************************
    // assertions
    // ******************************************************************

    // the router only issues reads to banks that exist.
    a_last_bank_range: assert property (
        @(posedge clk) disable iff (reset) int'(last_bank) < NUM_BANKS
    ) else $error("last read bank %0d is past the last bank.", last_bank);

endmodule

/* glb_top.sv */
module glb_top #(
    parameter int DATA_WIDTH = glb_cfg_pkg::DEFAULT_DATA_WIDTH,
    parameter int BANK_WORDS = glb_cfg_pkg::DEFAULT_BANK_WORDS,
    parameter int NUM_BANKS  = glb_cfg_pkg::DEFAULT_NUM_BANKS,
    localparam int LOCAL_AW  = glb_cfg_pkg::local_addr_bits(BANK_WORDS),
    localparam int BANK_IW   = glb_cfg_pkg::bank_idx_bits(NUM_BANKS),
    localparam int GLOBAL_AW = glb_cfg_pkg::global_addr_bits(BANK_WORDS, NUM_BANKS)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  glb_cmd_pkg::glb_op_e  cmd_op,
    input  logic [GLOBAL_AW-1:0]  cmd_addr,
    input  logic [DATA_WIDTH-1:0] cmd_wdata,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rdata_valid,
    output logic                  cmd_err
);

    logic [NUM_BANKS-1:0]  bank_read_en;
    logic [NUM_BANKS-1:0]  bank_write_en;
    logic [LOCAL_AW-1:0]   bank_addr;
    logic [DATA_WIDTH-1:0] bank_wdata;
    logic [DATA_WIDTH-1:0] bank_rdata [NUM_BANKS];
    logic                  rd_issue;
    logic [BANK_IW-1:0]    rd_bank;

    glb_router #(
        .DATA_WIDTH (DATA_WIDTH),
        .BANK_WORDS (BANK_WORDS),
        .NUM_BANKS  (NUM_BANKS)
    ) u_router (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_addr      (cmd_addr),
        .cmd_wdata     (cmd_wdata),
        .bank_read_en  (bank_read_en),
        .bank_write_en (bank_write_en),
        .bank_addr     (bank_addr),
        .bank_wdata    (bank_wdata),
        .rd_issue      (rd_issue),
        .rd_bank       (rd_bank),
        .cmd_err       (cmd_err)
    );

    // address and write data are shared, the enables pick the bank.
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        glb_bank #(
            .DATA_WIDTH (DATA_WIDTH),
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clk      (clk),
            .reset    (reset),
            .read_en  (bank_read_en[i]),
            .write_en (bank_write_en[i]),
            .addr     (bank_addr),
            .data_in  (bank_wdata),
            .data_out (bank_rdata[i])
        );
    end

    glb_collector #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_BANKS  (NUM_BANKS)
    ) u_collector (
        .clk         (clk),
        .reset       (reset),
        .rd_issue    (rd_issue),
        .rd_bank     (rd_bank),
        .bank_rdata  (bank_rdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

/* tb_glb.sv */
module tb_glb;

    timeunit 1ns;
    timeprecision 100ps;

    import glb_cfg_pkg::*;
    import glb_cmd_pkg::*;

    localparam int DW  = DEFAULT_DATA_WIDTH;
    localparam int BW  = DEFAULT_BANK_WORDS;
    localparam int NB  = DEFAULT_NUM_BANKS;
    localparam int LAW = local_addr_bits(BW);
    localparam int GAW = global_addr_bits(BW, NB);
    localparam int VALID_TIMEOUT = 8;  // cycles allowed for a read to return.

    logic           clk;
    logic           reset;
    logic           cmd_valid;
    glb_op_e        cmd_op;
    logic [GAW-1:0] cmd_addr;
    logic [DW-1:0]  cmd_wdata;
    logic [DW-1:0]  rdata;
    logic           rdata_valid;
    logic           cmd_err;

    logic [DW-1:0] ref_mem [NB][BW];
    logic          ref_written [NB][BW];
    logic [DW-1:0] exp_rdata;
    logic [31:0]   lfsr_state;
    int            locs [NB][4];
    int            error_count;
    int            check_count;
    int            test_start_errors;

    glb_top uut (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .cmd_err     (cmd_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ******************************************************************
    // stimulus helpers
    // ******************************************************************

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [GAW-1:0] make_addr(input int bank, input int loc);
        return GAW'(bank * BW + loc);  // bank field above the local field.
    endfunction

    task automatic compare_word(input logic [DW-1:0] got, input logic [DW-1:0] expected,
                                input string what);
        check_count++;
        if (got !== expected) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_bit(input logic got, input logic expected, input string what);
        check_count++;
        if (got !== expected) begin
            $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, expected);
            error_count++;
        end
    endtask

    // drives one command, lets it be accepted, then checks the cycle after.
    task automatic run_cmd(input logic valid, input glb_op_e op, input int bank,
                           input int loc, input logic [DW-1:0] wdata);
        logic exp_valid;
        logic exp_err;
        logic legal;
        legal     = (bank < NB);
        exp_valid = 1'b0;
        exp_err   = 1'b0;
        cmd_valid = valid;
        cmd_op    = op;
        cmd_addr  = make_addr(bank, loc);
        cmd_wdata = wdata;
        if (valid) begin
            case (op)
                OP_READ: begin
                    exp_err = !legal;
                    if (legal) begin
                        exp_valid = 1'b1;
                        exp_rdata = ref_mem[bank][loc];
                    end
                end
                OP_WRITE: begin
                    exp_err = !legal;
                    if (legal) begin
                        ref_mem[bank][loc]     = wdata;
                        ref_written[bank][loc] = 1'b1;
                    end
                end
                OP_BCAST: begin
                    for (int b = 0; b < NB; b++) begin
                        ref_mem[b][loc]     = wdata;
                        ref_written[b][loc] = 1'b1;
                    end
                end
                default: ;
            endcase
        end
        @(posedge clk);
        #1;
        compare_bit(rdata_valid, exp_valid, "rdata_valid");
        compare_bit(cmd_err, exp_err, "cmd_err");
        compare_word(rdata, exp_rdata, "rdata");
        #1;
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            run_cmd(1'b0, OP_NOP, 0, 0, '0);
        end
    endtask

    task automatic read_and_wait(input int bank, input int loc);
        int   waited;
        logic done;
        waited    = 0;
        done      = 1'b0;
        cmd_valid = 1'b1;
        cmd_op    = OP_READ;
        cmd_addr  = make_addr(bank, loc);
        while (!done) begin
            @(posedge clk);
            #1;
            waited++;
            compare_bit(cmd_err, 1'b0, "cmd_err during read");
            if (rdata_valid) begin
                done = 1'b1;
                compare_word(rdata, ref_mem[bank][loc], "read data");
                if (waited != 1) begin
                    $display("[ERROR] %0d ns: read latency %0d cycles", $time, waited);
                    error_count++;
                end
            end else if (waited >= VALID_TIMEOUT) begin
                done = 1'b1;
                $display("timeout: no rdata_valid for bank %0d address %0d", bank, loc);
                error_count++;
            end
            #1;
            cmd_valid = 1'b0;
        end
        exp_rdata = ref_mem[bank][loc];
    endtask

    task automatic end_test(input string name);
        $display("%-24s %s", name, (error_count == test_start_errors) ? "passed" : "failed");
        test_start_errors = error_count;
    endtask

    // ******************************************************************
    // tests
    // ******************************************************************

    task automatic test_reset_state();
        idle(5);  // rdata stays zero and no pulses appear.
        end_test("reset state");
    endtask

    task automatic test_write_read();
        for (int b = 0; b < NB; b++) begin
            for (int k = 0; k < 4; k++) begin
                locs[b][k] = int'(rand_bits(LAW));
                run_cmd(1'b1, OP_WRITE, b, locs[b][k], rand_bits(DW));
            end
        end
        for (int b = 0; b < NB; b++) begin
            for (int k = 0; k < 4; k++) begin
                read_and_wait(b, locs[b][k]);
            end
        end
        for (int b = 0; b < NB; b++) begin
            run_cmd(1'b1, OP_READ, b, locs[b][0], '0);  // back to back across banks.
        end
        run_cmd(1'b1, OP_READ, 2, locs[2][1], '0);
        run_cmd(1'b1, OP_READ, 0, locs[0][2], '0);
        idle(2);
        end_test("write then read");
    endtask

    task automatic test_hold();
        read_and_wait(1, locs[1][1]);
        idle(3);
        run_cmd(1'b1, OP_WRITE, 0, locs[0][1], rand_bits(DW));
        run_cmd(1'b1, OP_WRITE, 2, locs[2][3], rand_bits(DW));
        run_cmd(1'b1, OP_WRITE, 1, (locs[1][1] + 1) % BW, rand_bits(DW));
        run_cmd(1'b1, OP_WRITE, 1, locs[1][1], rand_bits(DW));  // rdata holds over this write.
        run_cmd(1'b1, OP_NOP, 1, locs[1][1], '0);
        idle(2);
        end_test("hold");
    endtask

    task automatic test_broadcast();
        int loc_a;
        int loc_b;
        loc_a = int'(rand_bits(LAW));
        loc_b = (loc_a + 7) % BW;
        run_cmd(1'b1, OP_BCAST, 3, loc_a, rand_bits(DW));  // bank field past the last bank.
        run_cmd(1'b1, OP_BCAST, 1, loc_b, rand_bits(DW));
        for (int b = 0; b < NB; b++) begin
            read_and_wait(b, loc_a);
            read_and_wait(b, loc_b);
        end
        end_test("broadcast");
    endtask

    task automatic test_illegal_bank();
        int loc;
        loc = int'(rand_bits(LAW));
        run_cmd(1'b1, OP_BCAST, 0, loc, rand_bits(DW));
        run_cmd(1'b1, OP_WRITE, 3, loc, rand_bits(DW));
        run_cmd(1'b1, OP_READ, 3, loc, '0);
        idle(2);
        for (int b = 0; b < NB; b++) begin
            read_and_wait(b, loc);
        end
        end_test("illegal bank");
    endtask

    task automatic test_random();
        glb_op_e op;
        logic    valid;
        int      bank;
        int      loc;
        for (int i = 0; i < 200; i++) begin
            op    = glb_op_e'(rand_bits(OP_WIDTH));
            bank  = int'(rand_bits(2));
            loc   = int'(rand_bits(LAW));
            valid = (rand_bits(3) != 0);
            // reads only go to words with a known value.
            if (op == OP_READ && bank < NB && !ref_written[bank][loc]) begin
                op = OP_WRITE;
            end
            run_cmd(valid, op, bank, loc, rand_bits(DW));
        end
        idle(2);
        end_test("random sequence");
    endtask

    // ******************************************************************
    // main sequence
    // ******************************************************************

    initial begin
        reset             = 1'b1;
        cmd_valid         = 1'b0;
        cmd_op            = OP_NOP;
        cmd_addr          = '0;
        cmd_wdata         = '0;
        exp_rdata         = '0;
        lfsr_state        = 32'hb60e2a4c;
        error_count       = 0;
        check_count       = 0;
        test_start_errors = 0;
        for (int b = 0; b < NB; b++) begin
            for (int a = 0; a < BW; a++) begin
                ref_written[b][a] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_state();
        test_write_read();
        test_hold();
        test_broadcast();
        test_illegal_bank();
        test_random();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // whole-run watchdog.
    initial begin
        #100_000;
        $display("simulation timeout: the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* vlog.f */
glb_cfg_pkg.sv
glb_cmd_pkg.sv
sram_sp_model.sv
glb_bank.sv
glb_router.sv
glb_collector.sv
glb_top.sv
tb_glb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_glb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
